/* src/wbuf_pkg.sv */
// write buffer geometry, external write port, burst command and memory-side word types
package wbuf_pkg;

    // geometry of the write channel buffer
    localparam int EXT_AW      = 10;                 // 1K x 32 host side
    localparam int EXT_DW      = 32;
    localparam int PAGE_W      = 2;                  // four pages
    localparam int WORD_AW     = 7;                  // 128 64-bit words per page
    localparam int MEM_DW      = 64;                 // controller side word
    localparam int RAM_AW      = PAGE_W + WORD_AW;   // 512 x 64 read side
    localparam int RAM_OUT_REG = 1;                  // second read stage on by default

    // host write port, sampled on ext_clk
    typedef struct packed {
        logic              we;      // one word per cycle
        logic [EXT_AW-1:0] waddr;   // bit 0 selects low/high half
        logic [EXT_DW-1:0] data;
    } ext_wr_t;                     // 43 bits

    // burst command, qualified by a one-cycle start
    typedef struct packed {
        logic               set_page;   // load page before reading
        logic [PAGE_W-1:0]  page;
        logic [WORD_AW-1:0] len_m1;     // words minus one
    } burst_cmd_t;                      // 10 bits

    // word handed to the memory side with wvalid
    typedef struct packed {
        logic              last;    // final word of the burst
        logic [MEM_DW-1:0] data;    // {odd word, even word}
    } mem_wdata_t;                  // 65 bits

endpackage

/* src/ram_1kx32w_512x64r.sv */
// dual-clock ram, 32-bit write on ext_clk, 64-bit read on rclk with optional output register
`timescale 1ns/100ps

module ram_1kx32w_512x64r #(
    parameter int REGISTERS = wbuf_pkg::RAM_OUT_REG   // 1: data_out loaded on regen
) (
    input  logic                        rclk,
    input  logic                        rst_n,
    input  logic                        ren,       // capture read word
    input  logic                        regen,     // load output stage
    input  logic [wbuf_pkg::RAM_AW-1:0] raddr,     // {page, word}
    output logic [wbuf_pkg::MEM_DW-1:0] data_out,
    input  logic                        ext_clk,
    input  wbuf_pkg::ext_wr_t           wr
);

    localparam int BANK_AW = wbuf_pkg::EXT_AW - 1;   // per-half address
    localparam int BANK_D  = 1 << BANK_AW;

    // two 512 x 32 halves, even addresses in lo
    logic [wbuf_pkg::EXT_DW-1:0] mem_lo [BANK_D];
    logic [wbuf_pkg::EXT_DW-1:0] mem_hi [BANK_D];

    logic [wbuf_pkg::MEM_DW-1:0] rd_latch;          // first read stage
    logic [BANK_AW-1:0]          wr_bank_addr;

    assign wr_bank_addr = wr.waddr[wbuf_pkg::EXT_AW-1:1];   // drop half select

    // write side, ext_clk domain
    always_ff @(posedge ext_clk) begin
        if (wr.we) begin
            if (wr.waddr[0]) begin
                mem_hi[wr_bank_addr] <= wr.data;    // odd -> bits 63:32
            end else begin
                mem_lo[wr_bank_addr] <= wr.data;    // even -> bits 31:0
            end
        end
    end

    // read side, both halves at once
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_latch <= '0;
        end else if (ren) begin
            rd_latch <= {mem_hi[raddr], mem_lo[raddr]};
        end
    end

    generate
        if (REGISTERS != 0) begin : g_out_reg
            logic [wbuf_pkg::MEM_DW-1:0] out_q;     // second stage

            always_ff @(posedge rclk or negedge rst_n) begin
                if (!rst_n) begin
                    out_q <= '0;
                end else if (regen) begin
                    out_q <= rd_latch;
                end
            end

            assign data_out = out_q;
        end else begin : g_no_out_reg
            // latch stage straight out, regen not needed here
            assign data_out = rd_latch;
        end
    endgenerate

endmodule

/* src/mcntrl_1kx32w.sv */
// paged read buffer with page register and auto-incrementing read address
`timescale 1ns/100ps

module mcntrl_1kx32w (
    input  logic                         rclk,
    input  logic                         rst_n,
    input  logic                         ext_clk,
    input  wbuf_pkg::ext_wr_t            ext_wr,     // host side, ext_clk
    input  logic [wbuf_pkg::PAGE_W-1:0]  rpage_in,
    input  logic                         rpage_set,  // wins over page_next
    input  logic                         page_next,  // next page, address to 0
    input  logic                         rd,         // one word per cycle
    output logic [wbuf_pkg::PAGE_W-1:0]  page,
    output logic [wbuf_pkg::MEM_DW-1:0]  data_out
);

    logic [wbuf_pkg::PAGE_W-1:0]  page_q;
    logic [wbuf_pkg::WORD_AW-1:0] raddr_q;    // word inside page
    logic                         regen_q;    // rd one cycle late

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            page_q  <= '0;
            raddr_q <= '0;
            regen_q <= 1'b0;
        end else begin
            regen_q <= rd;                     // output stage follows read

            if (rpage_set) begin
                page_q <= rpage_in;
            end else if (page_next) begin
                page_q <= page_q + 1'b1;       // 3 wraps to 0
            end

            if (page_next) begin
                raddr_q <= '0;
            end else if (rd) begin
                raddr_q <= raddr_q + 1'b1;     // ram sees pre-increment value
            end
        end
    end

    assign page = page_q;

    ram_1kx32w_512x64r #(
        .REGISTERS (wbuf_pkg::RAM_OUT_REG)
    ) u_ram (
        .rclk     (rclk),
        .rst_n    (rst_n),
        .ren      (rd),
        .regen    (regen_q),
        .raddr    ({page_q, raddr_q}),   // 2 + 7 bits
        .data_out (data_out),
        .ext_clk  (ext_clk),
        .wr       (ext_wr)
    );

endmodule

/* src/wbuf_burst_reader.sv */
// burst sequencer: page set, read strobes, page advance, valid/last/done aligned to ram data
`timescale 1ns/100ps

module wbuf_burst_reader (
    input  logic                         rclk,
    input  logic                         rst_n,
    input  logic                         start,       // one-cycle pulse
    input  wbuf_pkg::burst_cmd_t         cmd,
    output logic                         rpage_set,
    output logic [wbuf_pkg::PAGE_W-1:0]  rpage_in,
    output logic                         rd,
    output logic                         page_next,
    input  logic [wbuf_pkg::MEM_DW-1:0]  data_in,     // ram output, 2 cycles after rd
    output wbuf_pkg::mem_wdata_t         wdata,
    output logic                         wvalid,
    output logic                         done,
    output logic                         busy
);

    logic                         accept;     // start taken this cycle
    logic                         busy_q;
    logic                         arm_q;      // gap cycle before first rd
    logic                         rd_q;
    logic [wbuf_pkg::WORD_AW-1:0] cnt_q;      // words left minus one
    logic                         last_rd;    // final rd of the burst
    logic                         rd_d1;      // rd at ram latch stage
    logic                         last_d1;
    logic                         wvalid_q;   // rd at ram output stage
    logic                         wlast_q;

    assign accept  = start & ~busy_q;           // ignored while running
    assign last_rd = rd_q & (cnt_q == '0);

    // page load goes straight to the buffer, lands on the accept edge
    assign rpage_set = accept & cmd.set_page;
    assign rpage_in  = cmd.page;

    // command and read strobe sequencing
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            arm_q  <= 1'b0;
            rd_q   <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
                arm_q  <= 1'b1;
                cnt_q  <= cmd.len_m1;
            end else if (wlast_q) begin
                busy_q <= 1'b0;                 // last word has left
            end

            if (arm_q) begin
                arm_q <= 1'b0;
                rd_q  <= 1'b1;                  // first read
            end else if (rd_q) begin
                if (cnt_q == '0) begin
                    rd_q <= 1'b0;               // burst issued
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    // two-stage shift tracking ram latency
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_d1    <= 1'b0;
            last_d1  <= 1'b0;
            wvalid_q <= 1'b0;
            wlast_q  <= 1'b0;
        end else begin
            rd_d1    <= rd_q;
            last_d1  <= last_rd;
            wvalid_q <= rd_d1;
            wlast_q  <= last_d1;
        end
    end

    assign rd        = rd_q;
    assign page_next = last_rd;       // advance page, clear address

    assign wdata.last = wlast_q;
    assign wdata.data = data_in;      // meaningful only with wvalid
    assign wvalid     = wvalid_q;
    assign done       = wlast_q;      // same cycle as the last word
    assign busy       = busy_q;

endmodule

/* src/mcntrl_wbuf_top.sv */
// write channel buffer top: paged buffer plus burst reader
`timescale 1ns/100ps

module mcntrl_wbuf_top (
    input  logic                         rclk,
    input  logic                         rst_n,
    input  logic                         ext_clk,
    input  wbuf_pkg::ext_wr_t            ext_wr,   // host writes, ext_clk
    input  logic                         start,
    input  wbuf_pkg::burst_cmd_t         cmd,
    output wbuf_pkg::mem_wdata_t         wdata,    // to memory side
    output logic                         wvalid,
    output logic                         done,
    output logic                         busy,
    output logic [wbuf_pkg::PAGE_W-1:0]  page
);

    logic                         rpage_set;
    logic [wbuf_pkg::PAGE_W-1:0]  rpage_in;
    logic                         rd;
    logic                         page_next;
    logic [wbuf_pkg::MEM_DW-1:0]  buf_data;    // ram read word

    mcntrl_1kx32w u_buf (
        .rclk      (rclk),
        .rst_n     (rst_n),
        .ext_clk   (ext_clk),
        .ext_wr    (ext_wr),
        .rpage_in  (rpage_in),
        .rpage_set (rpage_set),
        .page_next (page_next),
        .rd        (rd),
        .page      (page),
        .data_out  (buf_data)
    );

    wbuf_burst_reader u_reader (
        .rclk      (rclk),
        .rst_n     (rst_n),
        .start     (start),
        .cmd       (cmd),
        .rpage_set (rpage_set),
        .rpage_in  (rpage_in),
        .rd        (rd),
        .page_next (page_next),
        .data_in   (buf_data),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .done      (done),
        .busy      (busy)
    );

endmodule

/* sim/wbuf_checker.sv */
// strobe assertions for the burst reader and their bind into wbuf_burst_reader
`timescale 1ns/100ps

module wbuf_checker (
    input logic                 rclk,
    input logic                 rst_n,
    input logic                 rd,
    input logic                 page_next,
    input wbuf_pkg::mem_wdata_t wdata,
    input logic                 wvalid,
    input logic                 done,
    input logic                 busy
);

    int unsigned fail_count = 0;   // read by the testbench at the end

    a_done_last: assert property (@(posedge rclk) disable iff (!rst_n)
        done |-> (wvalid && wdata.last))
        else begin
            fail_count++;
            $error("done without wvalid and wlast");
        end

    a_valid_busy: assert property (@(posedge rclk) disable iff (!rst_n)
        wvalid |-> busy)
        else begin
            fail_count++;
            $error("wvalid while not busy");
        end

    a_next_rd: assert property (@(posedge rclk) disable iff (!rst_n)
        page_next |-> rd)
        else begin
            fail_count++;
            $error("page_next without rd");
        end

    a_reset_quiet: assert property (@(posedge rclk)
        !rst_n |-> !(rd || page_next || wvalid || wdata.last || done || busy))
        else begin
            fail_count++;
            $error("strobe high during reset");
        end

endmodule

bind wbuf_burst_reader wbuf_checker u_chk (
    .rclk      (rclk),
    .rst_n     (rst_n),
    .rd        (rd),
    .page_next (page_next),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .done      (done),
    .busy      (busy)
);

/* sim/tb_mcntrl_wbuf.sv */
// testbench for the write channel buffer: clocks, reset, reference model, directed tests, watchdog
`timescale 1ns/100ps

module tb_mcntrl_wbuf;

    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = NUM_TESTS * (1024 + 140) * 2 * 10;   // per test, x2 margin

    logic                        rclk;
    logic                        ext_clk;
    logic                        rst_n;
    wbuf_pkg::ext_wr_t           ext_wr;
    logic                        start;
    wbuf_pkg::burst_cmd_t        cmd;
    wbuf_pkg::mem_wdata_t        wdata;
    logic                        wvalid;
    logic                        done;
    logic                        busy;
    logic [wbuf_pkg::PAGE_W-1:0] page;

    logic [wbuf_pkg::EXT_DW-1:0] ref_mem [1 << wbuf_pkg::EXT_AW];   // mirror of host writes
    logic [wbuf_pkg::PAGE_W-1:0] model_page;   // page the next burst reads
    integer                      seed;

    mcntrl_wbuf_top dut0 (
        .rclk    (rclk),
        .rst_n   (rst_n),
        .ext_clk (ext_clk),
        .ext_wr  (ext_wr),
        .start   (start),
        .cmd     (cmd),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .done    (done),
        .busy    (busy),
        .page    (page)
    );

    initial begin
        rclk = 1'b0;
        forever #4 rclk = ~rclk;          // 8 ns controller clock
    end

    initial begin
        ext_clk = 1'b0;
        forever #5 ext_clk = ~ext_clk;    // 10 ns host clock
    end

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_val(input string test, input string what,
                             input logic [63:0] exp_v, input logic [63:0] act_v);
        if (act_v !== exp_v) begin
            $display("FAIL %s: %s expected %h actual %h", test, what, exp_v, act_v);
            stop_on_error();
        end
    endtask

    // 64-bit word i of page pg, even address in the low half
    function automatic logic [63:0] exp_word(input logic [1:0] pg, input int i);
        int base;
        base = int'(pg) * 256 + 2 * i;
        return {ref_mem[base + 1], ref_mem[base]};
    endfunction

    task automatic write_range(input int base, input int count);
        wbuf_pkg::ext_wr_t w;
        for (int a = base; a < base + count; a++) begin
            w.we    = 1'b1;
            w.waddr = a[wbuf_pkg::EXT_AW-1:0];
            w.data  = $random(seed);
            ref_mem[a] = w.data;                  // model follows every write
            @(posedge ext_clk);
            ext_wr <= w;
        end
        @(posedge ext_clk);                       // last word lands here
        ext_wr.we <= 1'b0;
    endtask

    // start at E0, then walk the cycles after E0, E1 ... at the falling edge
    task automatic do_burst(input string test, input bit set_pg, input logic [1:0] pg,
                            input logic [6:0] len_m1, input int spur_drive_edge);
        wbuf_pkg::burst_cmd_t c;
        wbuf_pkg::burst_cmd_t spur;
        int                   len;
        int                   k;
        int                   nwords;
        bit                   got_done;
        bit                   exp_valid;
        c.set_page    = set_pg;
        c.page        = pg;
        c.len_m1      = len_m1;
        spur.set_page = 1'b1;
        spur.page     = pg + 2'd2;               // would move the page if taken
        spur.len_m1   = 7'd50;
        len      = int'(len_m1) + 1;
        nwords   = 0;
        got_done = 1'b0;
        if (set_pg) begin
            model_page = pg;
        end
        @(posedge rclk);
        start <= 1'b1;
        cmd   <= c;
        @(posedge rclk);                          // E0 samples start
        start <= 1'b0;
        k = 0;
        while (!got_done && k <= len + 8) begin
            @(negedge rclk);                      // cycle after E(k)
            exp_valid = (k >= 3) && (k <= len + 2);
            check_val(test, "busy", 1, busy);
            check_val(test, "wvalid", exp_valid, wvalid);
            check_val(test, "wlast", k == len + 2, wdata.last);
            if (wvalid) begin
                check_val(test, $sformatf("word %0d of page %0d", nwords, model_page),
                          exp_word(model_page, nwords), wdata.data);
                nwords++;
            end
            if (done) begin
                got_done = 1'b1;
                check_val(test, "done cycle", len + 2, k);
            end
            @(posedge rclk);
            if (k + 1 == spur_drive_edge) begin
                start <= 1'b1;                    // lands while busy
                cmd   <= spur;
            end else begin
                start <= 1'b0;
            end
            k++;
        end
        if (!got_done) begin
            $display("%s: no done pulse within %0d cycles of the start", test, len + 8);
            stop_on_error();
        end
        check_val(test, "word count", len, nwords);
        @(negedge rclk);                          // cycle after E(len+3)
        check_val(test, "busy after done", 0, busy);
        check_val(test, "wvalid after done", 0, wvalid);
        model_page = model_page + 1'b1;           // page_next on the final rd
        check_val(test, "page", model_page, page);
    endtask

    task automatic expect_idle(input string test, input int cycles);
        repeat (cycles) begin
            @(negedge rclk);
            check_val(test, "idle busy", 0, busy);
            check_val(test, "idle wvalid", 0, wvalid);
            check_val(test, "idle done", 0, done);
        end
    endtask

    task automatic test_full_page();
        write_range(2 * 256, 256);
        do_burst("full_page", 1'b1, 2'd2, 7'd127, -1);
        check_val("full_page", "page after burst", 3, page);
    endtask

    task automatic test_fixed_latency();
        write_range(0, 10);
        do_burst("fixed_latency", 1'b1, 2'd0, 7'd4, -1);   // wvalid after E3..E7
        expect_idle("fixed_latency", 4);
    endtask

    task automatic test_continue();
        write_range(1 * 256, 8);
        write_range(2 * 256, 8);
        do_burst("continue", 1'b1, 2'd1, 7'd3, -1);
        check_val("continue", "page after first burst", 2, page);
        do_burst("continue", 1'b0, 2'd0, 7'd3, -1);        // page 2, word 0 on
    endtask

    task automatic test_page_wrap();
        write_range(3 * 256, 16);
        write_range(0, 16);
        do_burst("page_wrap", 1'b1, 2'd3, 7'd7, -1);
        check_val("page_wrap", "page after wrap", 0, page);
        do_burst("page_wrap", 1'b0, 2'd0, 7'd7, -1);       // reads page 0
        check_val("page_wrap", "page after second burst", 1, page);
    endtask

    task automatic test_start_busy();
        write_range(1 * 256, 20);
        do_burst("start_busy", 1'b1, 2'd1, 7'd9, 4);       // second start at E5
        check_val("start_busy", "page after burst", 2, page);
        expect_idle("start_busy", 10);
    endtask

    task automatic test_random_sweep();
        logic [31:0] r;
        write_range(0, 1 << wbuf_pkg::EXT_AW);
        for (int b = 0; b < 8; b++) begin
            r = $random(seed);
            do_burst("random_sweep", 1'b1, b[1:0], r[6:0], -1);
        end
    endtask

    initial begin
        seed       = 32'h9a24;
        model_page = '0;
        rst_n  <= 1'b0;
        start  <= 1'b0;
        cmd    <= '0;
        ext_wr <= '0;
        repeat (3) @(posedge rclk);
        rst_n <= 1'b1;
        @(posedge rclk);
        test_full_page();
        test_fixed_latency();
        test_continue();
        test_page_wrap();
        test_start_busy();
        test_random_sweep();
        if (dut0.u_reader.u_chk.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("checker assertions failed %0d times", dut0.u_reader.u_chk.fail_count);
            stop_on_error();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        stop_on_error();
    end

endmodule

/* all.f */
src/wbuf_pkg.sv
src/ram_1kx32w_512x64r.sv
src/mcntrl_1kx32w.sv
src/wbuf_burst_reader.sv
src/mcntrl_wbuf_top.sv
sim/wbuf_checker.sv
sim/tb_mcntrl_wbuf.sv

/* Bender.yml */
package:
  name: mcntrl_wbuf

dependencies: {}

sources:
  # design, in compile order
  - files:
      - src/wbuf_pkg.sv
      - src/ram_1kx32w_512x64r.sv
      - src/mcntrl_1kx32w.sv
      - src/wbuf_burst_reader.sv
      - src/mcntrl_wbuf_top.sv

  # testbench and bound checker
  - target: simulation
    files:
      - sim/wbuf_checker.sv
      - sim/tb_mcntrl_wbuf.sv
